/* bench/load_store_core_tb.sv */
module load_store_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import axi_pkg::*;
    import core_pkg::*;

    localparam int RAM_LATENCY  = 2;
    localparam int TAIL_CYCLES  = 50;
    localparam int CLOCK_PERIOD = 100;

    logic      clock;
    logic      reset;
    logic      run;
    logic      load_wen;
    cmd_addr_t load_addr;
    axi_data_t load_data;
    logic      result_valid;
    axi_data_t result_data;
    logic      halted;

    cmd_addr_t preload_addr [$];
    axi_data_t preload_data [$];
    axi_data_t program_words [$];
    axi_data_t expected_data [$];
    string     expected_name [$];
    int        results_seen;
    bit        started;

    load_store_core #(
        .RAM_LATENCY (RAM_LATENCY)
    ) load_store_core_i (
        .clock        (clock),
        .reset        (reset),
        .run          (run),
        .load_wen     (load_wen),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .result_valid (result_valid),
        .result_data  (result_data),
        .halted       (halted)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks

    task automatic report_failure();
        $display("Test failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_result(input string name, input axi_data_t expected,
                                input axi_data_t actual);
        if (actual !== expected) begin
            $display("** Error [%s]: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("** Error [%s]: expected %0d, actual %0d", name, expected, actual);
            report_failure();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Vector file

    task automatic read_vectors();
        int        fd;
        int        code;
        string     line;
        string     tag;
        string     name;
        logic [31:0] addr;
        axi_data_t data;
        fd = $fopen("bench/load_store_core_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file");
            report_failure();
        end
        name = "unnamed";
        while (!$feof(fd)) begin
            tag = "";
            code = $fgets(line, fd);
            if (code > 0) begin
                code = $sscanf(line, "%s", tag);
            end
            if (tag == "P" || tag == "D") begin
                code = $sscanf(line, "%s %h %h", tag, addr, data);
                preload_addr.push_back(cmd_addr_t'(addr));
                preload_data.push_back(data);
                if (tag == "P") begin
                    program_words.push_back(data);
                end
            end else if (tag == "N") begin
                code = $sscanf(line, "%s %s", tag, name);
            end else if (tag == "E") begin
                code = $sscanf(line, "%s %h", tag, data);
                expected_data.push_back(data);
                expected_name.push_back(name);
            end
        end
        $fclose(fd);
    endtask

    // Loads up to the first halt, straight from the opcode field
    function automatic int count_loads();
        int      n;
        cmd_op_t op;
        n = 0;
        foreach (program_words[i]) begin
            op = cmd_op_t'(program_words[i][31:30]);
            if (op == OP_HALT) begin
                break;
            end
            if (op == OP_LOAD) begin
                n++;
            end
        end
        return n;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Result monitor, sampled away from the rising edge

    always @(negedge clock) begin
        if (!reset && result_valid) begin
            if (halted) begin
                $display("A load result appeared after the core halted");
                report_failure();
            end else if (results_seen >= expected_data.size()) begin
                $display("The core produced more load results than expected");
                report_failure();
            end else begin
                check_result(expected_name[results_seen], expected_data[results_seen],
                             result_data);
                results_seen++;
            end
        end
    end

    initial begin
        int limit;
        wait (started);
        limit = program_words.size() * (8 + RAM_LATENCY) * 2;
        repeat (limit) @(negedge clock);
        if (!halted) begin
            $display("The program never halted within %0d cycles", limit);
            report_failure();
        end
    end

    initial begin
        reset        = 1'b1;
        run          = 1'b0;
        load_wen     = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        results_seen = 0;
        started      = 1'b0;
        read_vectors();
        check_count("vector_file_loads", count_loads(), expected_data.size());
        repeat (2) @(negedge clock);
        reset = 1'b0;

        // Backdoor preload while the core is stopped
        foreach (preload_addr[i]) begin
            @(negedge clock);
            load_wen  = 1'b1;
            load_addr = preload_addr[i];
            load_data = preload_data[i];
        end
        @(negedge clock);
        load_wen = 1'b0;

        @(negedge clock);
        run     = 1'b1;
        started = 1'b1;
        while (!halted) @(negedge clock);
        repeat (TAIL_CYCLES) @(negedge clock);
        check_count("result_count", expected_data.size(), results_seen);
        $display("Test passed");
        $finish;
    end

endmodule

/* bench/load_store_core_vectors.txt */
# P <word index> <program word>, D <word index> <data word>, both preloaded by backdoor
# N <test name> names the E lines after it, E <expected result_data> in result order
D 040 CAFEF00D
D 042 11223344
D 043 55667788
P 000 A1000000
P 001 61041234
P 002 00000000
P 003 A1040000
P 004 410877AA
P 005 410977BB
P 006 410A77CC
P 007 410B77DD
P 008 A1080000
P 009 810A0000
P 00A 810B0000
P 00B 0ABC1234
P 00C 510CBEEF
P 00D 510FF00D
P 00E A10C0000
P 00F 910E0000
P 010 910D0000
P 011 C0000000
P 012 A1000000
N load_preloaded
E CAFEF00D
N word_store_load
E 00001234
N byte_lanes
E DDCCBBAA
E 000000CC
E 000000DD
N half_lanes
E F00DBEEF
E 0000F00D
E 0000BEEF

/* hdl/axi_interface.sv */
module axi_interface (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   io_master_awready,
    output logic                   io_master_awvalid,
    output axi_pkg::axi_addr_t     io_master_awaddr,
    output axi_pkg::axi_id_t       io_master_awid,
    output axi_pkg::axi_len_t      io_master_awlen,
    output axi_pkg::axi_size_t     io_master_awsize,
    output axi_pkg::axi_burst_t    io_master_awburst,
    input  logic                   io_master_wready,
    output logic                   io_master_wvalid,
    output axi_pkg::axi_data_t     io_master_wdata,
    output axi_pkg::axi_strb_t     io_master_wstrb,
    output logic                   io_master_wlast,
    output logic                   io_master_bready,
    input  logic                   io_master_bvalid,
    input  axi_pkg::axi_resp_t     io_master_bresp,
    input  axi_pkg::axi_id_t       io_master_bid,
    input  logic                   io_master_arready,
    output logic                   io_master_arvalid,
    output axi_pkg::axi_addr_t     io_master_araddr,
    output axi_pkg::axi_id_t       io_master_arid,
    output axi_pkg::axi_len_t      io_master_arlen,
    output axi_pkg::axi_size_t     io_master_arsize,
    output axi_pkg::axi_burst_t    io_master_arburst,
    output logic                   io_master_rready,
    input  logic                   io_master_rvalid,
    input  axi_pkg::axi_resp_t     io_master_rresp,
    input  axi_pkg::axi_data_t     io_master_rdata,
    input  logic                   io_master_rlast,
    input  axi_pkg::axi_id_t       io_master_rid,
    input  axi_pkg::axi_addr_t     pc,
    input  logic                   fetch_enable,
    output axi_pkg::axi_data_t     ist,
    output logic                   ist_valid,
    input  logic                   mem_wen,
    input  axi_pkg::axi_addr_t     mem_waddr,
    input  axi_pkg::axi_data_t     mem_wdata,
    input  axi_pkg::axi_strb_t     mem_wmask,
    input  logic                   mem_ren,
    input  axi_pkg::axi_addr_t     mem_raddr,
    input  axi_pkg::axi_strb_t     mem_rmask,
    output axi_pkg::axi_data_t     rdata_mem,
    output logic                   mem_rdone
);
    import axi_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        IFU_AR,
        IFU_R,
        EXEU,
        LSU_AW,
        LSU_W,
        LSU_AR,
        LSU_R
    } state_t;

    state_t state;
    state_t next_state;
    logic   aw_done;
    logic   w_done;
    logic   ar_done;
    logic   r_done;

    // Strobe pattern back to beat size
    function automatic axi_size_t mask_size(input axi_strb_t mask);
        case (mask)
            4'b0001, 4'b0010, 4'b0100, 4'b1000: return AXSIZE_1B;
            4'b0011, 4'b1100:                   return AXSIZE_2B;
            default:                            return AXSIZE_4B;
        endcase
    endfunction

    assign aw_done = io_master_awvalid && io_master_awready;
    assign w_done  = io_master_wvalid && io_master_wready;
    assign ar_done = io_master_arvalid && io_master_arready;
    assign r_done  = io_master_rvalid && io_master_rready;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:   next_state = fetch_enable ? IFU_AR : IDLE;
            IFU_AR: next_state = ar_done ? IFU_R : IFU_AR;
            IFU_R:  next_state = r_done ? EXEU : IFU_R;
            EXEU: begin
                if (mem_wen) begin
                    next_state = LSU_AW;
                end else if (mem_ren) begin
                    next_state = LSU_AR;
                end else if (fetch_enable) begin
                    next_state = IFU_AR;
                end else begin
                    next_state = IDLE;
                end
            end
            LSU_AW: next_state = aw_done ? LSU_W : LSU_AW;
            LSU_W:  next_state = w_done ? IFU_AR : LSU_W;
            LSU_AR: next_state = ar_done ? LSU_R : LSU_AR;
            LSU_R:  next_state = r_done ? IFU_AR : LSU_R;
            default: next_state = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Channel drive

    assign io_master_awvalid = state == LSU_AW;
    assign io_master_awaddr  = mem_waddr;
    assign io_master_awid    = '0;
    assign io_master_awlen   = '0;
    assign io_master_awsize  = mask_size(mem_wmask);
    assign io_master_awburst = BURST_INCR;

    assign io_master_wvalid = state == LSU_W;
    assign io_master_wdata  = mem_wdata;
    assign io_master_wstrb  = mem_wmask;
    assign io_master_wlast  = io_master_wvalid;
    assign io_master_bready = 1'b1;

    assign io_master_arvalid = state == IFU_AR || state == LSU_AR;
    assign io_master_araddr  = (state == IFU_AR) ? pc : mem_raddr;
    assign io_master_arid    = '0;
    assign io_master_arlen   = '0;
    assign io_master_arsize  = (state == IFU_AR) ? AXSIZE_4B : mask_size(mem_rmask);
    assign io_master_arburst = BURST_INCR;
    assign io_master_rready  = state == IFU_R || state == LSU_R;

    always_ff @(posedge clock) begin
        if (reset) begin
            ist       <= '0;
            ist_valid <= 1'b0;
        end else begin
            ist_valid <= state == IFU_R && r_done;
            if (state == IFU_R && r_done) begin
                ist <= io_master_rdata;
            end
        end
    end

    assign rdata_mem = io_master_rdata;
    assign mem_rdone = state == LSU_R && r_done;

endmodule

/* hdl/axi_pkg.sv */
package axi_pkg;

    typedef logic [31:0] axi_addr_t;
    typedef logic [31:0] axi_data_t;
    typedef logic [3:0]  axi_strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    localparam axi_burst_t BURST_INCR = 2'b01;
    localparam axi_resp_t  RESP_OKAY  = 2'b00;

    // Beat size encodings, bytes per beat = 2**size
    localparam axi_size_t AXSIZE_1B = 3'd0;
    localparam axi_size_t AXSIZE_2B = 3'd1;
    localparam axi_size_t AXSIZE_4B = 3'd2;

endpackage

/* hdl/axi_ram.sv */
module axi_ram #(
    parameter int RAM_WORDS   = 1024,
    parameter int RAM_LATENCY = 2
) (
    input  logic                   clock,
    input  logic                   reset,
    output logic                   io_master_awready,
    input  logic                   io_master_awvalid,
    input  axi_pkg::axi_addr_t     io_master_awaddr,
    input  axi_pkg::axi_id_t       io_master_awid,
    input  axi_pkg::axi_len_t      io_master_awlen,
    input  axi_pkg::axi_size_t     io_master_awsize,
    input  axi_pkg::axi_burst_t    io_master_awburst,
    output logic                   io_master_wready,
    input  logic                   io_master_wvalid,
    input  axi_pkg::axi_data_t     io_master_wdata,
    input  axi_pkg::axi_strb_t     io_master_wstrb,
    input  logic                   io_master_wlast,
    input  logic                   io_master_bready,
    output logic                   io_master_bvalid,
    output axi_pkg::axi_resp_t     io_master_bresp,
    output axi_pkg::axi_id_t       io_master_bid,
    output logic                   io_master_arready,
    input  logic                   io_master_arvalid,
    input  axi_pkg::axi_addr_t     io_master_araddr,
    input  axi_pkg::axi_id_t       io_master_arid,
    input  axi_pkg::axi_len_t      io_master_arlen,
    input  axi_pkg::axi_size_t     io_master_arsize,
    input  axi_pkg::axi_burst_t    io_master_arburst,
    input  logic                   io_master_rready,
    output logic                   io_master_rvalid,
    output axi_pkg::axi_resp_t     io_master_rresp,
    output axi_pkg::axi_data_t     io_master_rdata,
    output logic                   io_master_rlast,
    output axi_pkg::axi_id_t       io_master_rid,
    input  logic                   load_wen,
    input  core_pkg::cmd_addr_t    load_addr,
    input  axi_pkg::axi_data_t     load_data
);
    import axi_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);
    localparam int CNT_W = $clog2(RAM_LATENCY + 1);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WDATA,
        S_WRESP,
        S_READ
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] delay;
    axi_data_t        mem [RAM_WORDS];
    logic [IDX_W-1:0] wr_index;
    logic [IDX_W-1:0] rd_index;
    axi_id_t          bid_q;
    axi_id_t          rid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake sequencing, one transaction at a time

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_IDLE;
            delay <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (io_master_awvalid && io_master_awready) begin
                        state <= S_WDATA;
                    end else if (io_master_arvalid && io_master_arready) begin
                        state <= S_READ;
                        delay <= CNT_W'(RAM_LATENCY);
                    end
                end
                S_WDATA: if (io_master_wvalid) state <= S_WRESP;
                S_WRESP: if (io_master_bready) state <= S_IDLE;
                S_READ: begin
                    if (delay != '0) begin
                        delay <= delay - 1'b1;
                    end else if (io_master_rready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign io_master_awready = state == S_IDLE;
    // Write wins if both arrive together
    assign io_master_arready = state == S_IDLE && !io_master_awvalid;
    assign io_master_wready  = state == S_WDATA;
    assign io_master_bvalid  = state == S_WRESP;
    assign io_master_bresp   = RESP_OKAY;
    assign io_master_bid     = bid_q;
    assign io_master_rvalid  = state == S_READ && delay == '0;
    assign io_master_rdata   = mem[rd_index];
    assign io_master_rresp   = RESP_OKAY;
    assign io_master_rlast   = io_master_rvalid;
    assign io_master_rid     = rid_q;

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge clock) begin
        if (io_master_awvalid && io_master_awready) begin
            wr_index <= io_master_awaddr[IDX_W+1:2];
            bid_q    <= io_master_awid;
        end
        if (io_master_arvalid && io_master_arready) begin
            rd_index <= io_master_araddr[IDX_W+1:2];
            rid_q    <= io_master_arid;
        end
        if (io_master_wvalid && io_master_wready) begin
            for (int i = 0; i < 4; i++) begin
                if (io_master_wstrb[i]) begin
                    mem[wr_index][8*i +: 8] <= io_master_wdata[8*i +: 8];
                end
            end
        end
        // Backdoor address is a word index
        if (load_wen) begin
            mem[IDX_W'(load_addr)] <= load_data;
        end
    end

endmodule

/* hdl/core_pkg.sv */
package core_pkg;

    typedef enum logic [1:0] {
        OP_NOP,
        OP_STORE,
        OP_LOAD,
        OP_HALT
    } cmd_op_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } access_size_t;

    typedef logic [11:0] cmd_addr_t;

    // Command word, msb first
    typedef struct packed {
        cmd_op_t      op;
        access_size_t size;
        cmd_addr_t    addr;
        logic [15:0]  imm;
    } cmd_t;

    ////////////////////////////////////////////////////////////////////////////
    // Lane steering

    // Address bits below the access size are dropped here
    function automatic logic [1:0] lane_offset(input access_size_t size, input cmd_addr_t addr);
        case (size)
            SIZE_BYTE: return addr[1:0];
            SIZE_HALF: return {addr[1], 1'b0};
            default:   return 2'b00;
        endcase
    endfunction

    function automatic logic [3:0] lane_mask(input access_size_t size, input cmd_addr_t addr);
        case (size)
            SIZE_BYTE: return 4'b0001 << lane_offset(size, addr);
            SIZE_HALF: return 4'b0011 << lane_offset(size, addr);
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] lane_place(
        input logic [31:0] data,
        input access_size_t size,
        input cmd_addr_t addr
    );
        return data << {lane_offset(size, addr), 3'b000};
    endfunction

    function automatic logic [31:0] lane_extract(
        input logic [31:0] data,
        input access_size_t size,
        input cmd_addr_t addr
    );
        logic [31:0] shifted;
        shifted = data >> {lane_offset(size, addr), 3'b000};
        case (size)
            SIZE_BYTE: return {24'b0, shifted[7:0]};
            SIZE_HALF: return {16'b0, shifted[15:0]};
            default:   return shifted;
        endcase
    endfunction

endpackage

/* hdl/fetch_exec_unit.sv */
module fetch_exec_unit (
    input  logic                clock,
    input  logic                reset,
    input  logic                run,
    output axi_pkg::axi_addr_t  pc,
    output logic                fetch_enable,
    input  axi_pkg::axi_data_t  ist,
    input  logic                ist_valid,
    output logic                mem_wen,
    output axi_pkg::axi_addr_t  mem_waddr,
    output axi_pkg::axi_data_t  mem_wdata,
    output axi_pkg::axi_strb_t  mem_wmask,
    output logic                mem_ren,
    output axi_pkg::axi_addr_t  mem_raddr,
    output axi_pkg::axi_strb_t  mem_rmask,
    input  axi_pkg::axi_data_t  rdata_mem,
    input  logic                mem_rdone,
    output logic                result_valid,
    output axi_pkg::axi_data_t  result_data,
    output logic                halted
);
    import axi_pkg::*;
    import core_pkg::*;

    cmd_t         cmd;
    axi_strb_t    lanes;
    access_size_t ld_size;
    cmd_addr_t    ld_addr;

    ////////////////////////////////////////////////////////////////////////////
    // Decode

    // ist holds until the next fetch, so these levels stay put through LSU
    assign cmd   = cmd_t'(ist);
    assign lanes = lane_mask(cmd.size, cmd.addr);

    assign mem_wen   = cmd.op == OP_STORE;
    assign mem_waddr = axi_addr_t'(cmd.addr);
    assign mem_wdata = lane_place(axi_data_t'(cmd.imm), cmd.size, cmd.addr);
    assign mem_wmask = lanes;

    assign mem_ren   = cmd.op == OP_LOAD;
    assign mem_raddr = axi_addr_t'(cmd.addr);
    assign mem_rmask = lanes;

    // Drops combinationally on a halt so the interface idles out of EXEU
    assign fetch_enable = run && !halted && cmd.op != OP_HALT;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc           <= '0;
            halted       <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= mem_rdone;
            if (ist_valid) begin
                pc <= pc + 32'd4;
            end
            if (ist_valid && cmd.op == OP_HALT) begin
                halted <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load return

    always_ff @(posedge clock) begin
        if (ist_valid) begin
            ld_size <= cmd.size;
            ld_addr <= cmd.addr;
        end
        if (mem_rdone) begin
            result_data <= lane_extract(rdata_mem, ld_size, ld_addr);
        end
    end

endmodule

/* hdl/load_store_core.sv */
module load_store_core #(
    parameter int RAM_WORDS   = 1024,
    parameter int RAM_LATENCY = 2
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 load_wen,
    input  core_pkg::cmd_addr_t  load_addr,
    input  axi_pkg::axi_data_t   load_data,
    output logic                 result_valid,
    output axi_pkg::axi_data_t   result_data,
    output logic                 halted
);
    import axi_pkg::*;

    // Command side
    axi_addr_t pc;
    logic      fetch_enable;
    axi_data_t ist;
    logic      ist_valid;
    logic      mem_wen;
    logic      mem_ren;
    logic      mem_rdone;
    axi_addr_t mem_waddr, mem_raddr;
    axi_data_t mem_wdata, rdata_mem;
    axi_strb_t mem_wmask, mem_rmask;

    // Memory port
    logic       io_master_awvalid, io_master_awready;
    axi_addr_t  io_master_awaddr, io_master_araddr;
    axi_id_t    io_master_awid, io_master_bid, io_master_arid, io_master_rid;
    axi_len_t   io_master_awlen, io_master_arlen;
    axi_size_t  io_master_awsize, io_master_arsize;
    axi_burst_t io_master_awburst, io_master_arburst;
    logic       io_master_wvalid, io_master_wready, io_master_wlast;
    axi_data_t  io_master_wdata, io_master_rdata;
    axi_strb_t  io_master_wstrb;
    logic       io_master_bvalid, io_master_bready;
    axi_resp_t  io_master_bresp, io_master_rresp;
    logic       io_master_arvalid, io_master_arready;
    logic       io_master_rvalid, io_master_rready, io_master_rlast;

    fetch_exec_unit fetch_exec_unit_i (.*);

    axi_interface axi_interface_i (.*);

    axi_ram #(
        .RAM_WORDS   (RAM_WORDS),
        .RAM_LATENCY (RAM_LATENCY)
    ) axi_ram_i (.*);

endmodule

/* sim.f */
hdl/axi_pkg.sv
hdl/core_pkg.sv
hdl/axi_interface.sv
hdl/fetch_exec_unit.sv
hdl/axi_ram.sv
hdl/load_store_core.sv
bench/load_store_core_tb.sv
